/* hw/axil_pkg.sv */
package axil_pkg;

	// shared by AW and AR
	typedef struct packed {
		logic [31:0] addr;
	} axil_ax_t;

	typedef struct packed {
		logic [31:0] data;
		logic [3:0]  strb;
	} axil_w_t;

	typedef struct packed {
		logic [1:0] resp;
	} axil_b_t;

	typedef struct packed {
		logic [31:0] data;
		logic [1:0]  resp;
	} axil_r_t;

	localparam logic [1:0] RESP_OKAY   = 2'b00;
	localparam logic [1:0] RESP_SLVERR = 2'b10;

endpackage

/* hw/axil_sram.sv */
`timescale 1ns/1ps

module axil_sram import axil_pkg::*; #(
	parameter int MEM_WORDS = 256,
	parameter int READ_WAIT = 2   // at least 1
) (
	input  logic     tgt_m_aclk,
	input  logic     tgt_m_aresetn,
	input  axil_ax_t aw,
	input  logic     awvalid,
	output logic     awready,
	input  axil_w_t  w,
	input  logic     wvalid,
	output logic     wready,
	output axil_b_t  b,
	output logic     bvalid,
	input  logic     bready,
	input  axil_ax_t ar,
	input  logic     arvalid,
	output logic     arready,
	output axil_r_t  r,
	output logic     rvalid,
	input  logic     rready
);

	localparam int IDX_BITS = $clog2(MEM_WORDS);
	localparam int CNT_BITS = $clog2(READ_WAIT + 1);

	logic [31:0]         mem [MEM_WORDS];
	logic [29:0]         wr_word;
	logic [29:0]         rd_word;
	logic                wr_hit;
	logic                rd_hit;
	logic                wr_fire;
	logic                rd_fire;
	logic                rd_busy;
	logic [CNT_BITS-1:0] wait_cnt;

	assign wr_word = aw.addr[31:2];
	assign rd_word = ar.addr[31:2];
	assign wr_hit  = wr_word < MEM_WORDS;
	assign rd_hit  = rd_word < MEM_WORDS;
	assign wr_fire = awvalid && awready && wvalid && wready;
	assign rd_fire = arvalid && arready;

	// ########################################
	// write channel

	always_ff @(posedge tgt_m_aclk or negedge tgt_m_aresetn) begin
		if (!tgt_m_aresetn) begin
			awready <= 1'b0;
			wready  <= 1'b0;
			bvalid  <= 1'b0;
		end else begin
			if (awready) begin      // one cycle pulse
				awready <= 1'b0;
				wready  <= 1'b0;
			end else if (awvalid && wvalid && !bvalid) begin
				awready <= 1'b1;
				wready  <= 1'b1;
			end
			if (wr_fire)
				bvalid <= 1'b1;
			else if (bvalid && bready)
				bvalid <= 1'b0;
		end
	end

	always_ff @(posedge tgt_m_aclk) begin
		if (wr_fire) begin
			b.resp <= wr_hit ? RESP_OKAY : RESP_SLVERR;
			for (int i = 0; i < 4; i++) begin
				if (wr_hit && w.strb[i])
					mem[wr_word[IDX_BITS-1:0]][8*i +: 8] <= w.data[8*i +: 8];
			end
		end
		if (rd_fire) begin
			r.data <= rd_hit ? mem[rd_word[IDX_BITS-1:0]] : '0;
			r.resp <= rd_hit ? RESP_OKAY : RESP_SLVERR;
		end
	end

	// ########################################
	// read channel

	always_ff @(posedge tgt_m_aclk or negedge tgt_m_aresetn) begin
		if (!tgt_m_aresetn) begin
			arready  <= 1'b0;
			rvalid   <= 1'b0;
			rd_busy  <= 1'b0;
			wait_cnt <= '0;
		end else begin
			if (arready)
				arready <= 1'b0;
			else if (arvalid && !rd_busy && !rvalid)
				arready <= 1'b1;
			if (rd_fire) begin
				if (READ_WAIT <= 1) begin
					rvalid <= 1'b1;
				end else begin
					rd_busy  <= 1'b1;
					wait_cnt <= CNT_BITS'(READ_WAIT - 1);
				end
			end else if (rd_busy) begin
				wait_cnt <= wait_cnt - 1'b1;
				if (wait_cnt == CNT_BITS'(1)) begin  // last wait state
					rd_busy <= 1'b0;
					rvalid  <= 1'b1;
				end
			end
			if (rvalid && rready)
				rvalid <= 1'b0;
		end
	end

endmodule

/* hw/pci_bridge_top.sv */
`timescale 1ns/1ps

module pci_bridge_top import pci_pkg::*, axil_pkg::*; #(
	parameter int WIN_BITS  = 24,
	parameter int MEM_WORDS = 256,
	parameter int READ_WAIT = 2
) (
	input  logic        tgt_m_aclk,
	input  logic        tgt_m_aresetn,
	input  logic [31:0] addr,
	input  logic [31:0] adio_out,
	input  logic [1:0]  base_hit,
	input  logic        s_wrdn,
	input  logic        s_data,
	input  logic        s_data_vld,
	input  logic [3:0]  s_cbe,
	output logic [31:0] adio_in,
	output logic        s_ready,
	output logic        s_term,
	output logic        s_abort
);

	// register port
	win_cfg_t win_cfg;
	pci_req_t reg_req;
	reg_rsp_t reg_rsp;
	logic     reg_wr;
	logic     reg_rd;
	logic     abort_evt;

	// AXI4-Lite between bridge and memory
	axil_ax_t aw;
	axil_w_t  w;
	axil_b_t  b;
	axil_ax_t ar;
	axil_r_t  r;
	logic     awvalid;
	logic     awready;
	logic     wvalid;
	logic     wready;
	logic     bvalid;
	logic     bready;
	logic     arvalid;
	logic     arready;
	logic     rvalid;
	logic     rready;

	pci_target #(
		.WIN_BITS (WIN_BITS)
	) pci_target_inst (
		.tgt_m_aclk    (tgt_m_aclk),
		.tgt_m_aresetn (tgt_m_aresetn),
		.addr          (addr),
		.adio_out      (adio_out),
		.base_hit      (base_hit),
		.s_wrdn        (s_wrdn),
		.s_data        (s_data),
		.s_data_vld    (s_data_vld),
		.s_cbe         (s_cbe),
		.adio_in       (adio_in),
		.s_ready       (s_ready),
		.s_term        (s_term),
		.s_abort       (s_abort),
		.win_cfg       (win_cfg),
		.reg_wr        (reg_wr),
		.reg_rd        (reg_rd),
		.reg_req       (reg_req),
		.reg_rsp       (reg_rsp),
		.abort_evt     (abort_evt),
		.aw            (aw),
		.awvalid       (awvalid),
		.awready       (awready),
		.w             (w),
		.wvalid        (wvalid),
		.wready        (wready),
		.b             (b),
		.bvalid        (bvalid),
		.bready        (bready),
		.ar            (ar),
		.arvalid       (arvalid),
		.arready       (arready),
		.r             (r),
		.rvalid        (rvalid),
		.rready        (rready)
	);

	pci_win_regs #(
		.WIN_BITS (WIN_BITS)
	) pci_win_regs_inst (
		.tgt_m_aclk    (tgt_m_aclk),
		.tgt_m_aresetn (tgt_m_aresetn),
		.reg_wr        (reg_wr),
		.reg_rd        (reg_rd),
		.reg_req       (reg_req),
		.abort_evt     (abort_evt),
		.reg_rsp       (reg_rsp),
		.win_cfg       (win_cfg)
	);

	axil_sram #(
		.MEM_WORDS (MEM_WORDS),
		.READ_WAIT (READ_WAIT)
	) axil_sram_inst (
		.tgt_m_aclk    (tgt_m_aclk),
		.tgt_m_aresetn (tgt_m_aresetn),
		.aw            (aw),
		.awvalid       (awvalid),
		.awready       (awready),
		.w             (w),
		.wvalid        (wvalid),
		.wready        (wready),
		.b             (b),
		.bvalid        (bvalid),
		.bready        (bready),
		.ar            (ar),
		.arvalid       (arvalid),
		.arready       (arready),
		.r             (r),
		.rvalid        (rvalid),
		.rready        (rready)
	);

endmodule

/* hw/pci_pkg.sv */
package pci_pkg;

	// page bits get replaced by the window base
	typedef struct packed {
		logic [7:0]  page;
		logic [21:0] word;
		logic [1:0]  lane;
	} mem_addr_t;

	typedef struct packed {
		logic [27:0] rsvd;
		logic [1:0]  idx;  // register select
		logic [1:0]  lane;
	} reg_addr_t;

	// BAR 0 reads mem, BAR 1 reads regs
	typedef union packed {
		mem_addr_t mem;
		reg_addr_t regs;
	} pci_addr_u;

	typedef struct packed {
		pci_addr_u   addr;
		logic [31:0] data;
		logic [3:0]  be;   // active high
		logic        wrdn;
	} pci_req_t;

	typedef struct packed {
		logic [31:0] rdata;
	} reg_rsp_t;

	typedef struct packed {
		logic [31:0] base;  // only bits at and above WIN_BITS are held
		logic        enable;
	} win_cfg_t;

	localparam logic [1:0] REG_WIN_BASE  = 2'd0;
	localparam logic [1:0] REG_CTRL      = 2'd1;
	localparam logic [1:0] REG_ABORT_CNT = 2'd2;

endpackage

/* hw/pci_target.sv */
`timescale 1ns/1ps

module pci_target import pci_pkg::*, axil_pkg::*; #(
	parameter int WIN_BITS = 24
) (
	input  logic        tgt_m_aclk,
	input  logic        tgt_m_aresetn,
	// PCI user side
	input  logic [31:0] addr,
	input  logic [31:0] adio_out,
	input  logic [1:0]  base_hit,
	input  logic        s_wrdn,
	input  logic        s_data,
	input  logic        s_data_vld,
	input  logic [3:0]  s_cbe,
	output logic [31:0] adio_in,
	output logic        s_ready,
	output logic        s_term,
	output logic        s_abort,
	// register port
	input  win_cfg_t    win_cfg,
	output logic        reg_wr,
	output logic        reg_rd,
	output pci_req_t    reg_req,
	input  reg_rsp_t    reg_rsp,
	output logic        abort_evt,
	// AXI4-Lite master
	output axil_ax_t    aw,
	output logic        awvalid,
	input  logic        awready,
	output axil_w_t     w,
	output logic        wvalid,
	input  logic        wready,
	input  axil_b_t     b,
	input  logic        bvalid,
	output logic        bready,
	output axil_ax_t    ar,
	output logic        arvalid,
	input  logic        arready,
	input  axil_r_t     r,
	input  logic        rvalid,
	output logic        rready
);

	localparam logic [31:0] LO_MASK = (32'd1 << WIN_BITS) - 32'd1;

	typedef enum logic [1:0] {ST_IDLE, ST_DECODE, ST_MEM, ST_HOLD} state_t;
	typedef enum logic [2:0] {WS_IDLE, WS_REQ, WS_ACK, WS_WAIT, WS_DONE} ws_t;
	typedef enum logic [2:0] {RS_IDLE, RS_ASTB, RS_AWAIT, RS_DWAIT, RS_DONE} rs_t;

	state_t      state;
	ws_t         ws;
	rs_t         rs;
	pci_req_t    req;
	logic        req_mem;   // BAR 0 hit
	logic [31:0] axi_addr;
	logic        wr_start;
	logic        rd_start;
	logic        wr_done;
	logic        rd_done;
	logic        seq_ok;
	logic [1:0]  b_resp_q;
	axil_r_t     r_q;

	assign reg_req  = req;
	assign reg_wr   = (state == ST_DECODE) && !req_mem && req.wrdn;
	assign reg_rd   = (state == ST_DECODE) && !req_mem && !req.wrdn;
	assign wr_start = (state == ST_DECODE) && req_mem && win_cfg.enable && req.wrdn;
	assign rd_start = (state == ST_DECODE) && req_mem && win_cfg.enable && !req.wrdn;

	// window base above, PCI offset below
	assign axi_addr = (win_cfg.base & ~LO_MASK) | (req.addr.mem & LO_MASK);

	assign wr_done = (ws == WS_DONE);
	assign rd_done = (rs == RS_DONE);
	assign seq_ok  = wr_done ? (b_resp_q == RESP_OKAY) : (r_q.resp == RESP_OKAY);

	// ########################################
	// PCI side

	always_ff @(posedge tgt_m_aclk) begin
		if (state == ST_IDLE && base_hit != 2'b00) begin
			req.addr <= addr;
			req.data <= adio_out;
			req.be   <= ~s_cbe;
			req.wrdn <= s_wrdn;
			req_mem  <= base_hit[0];
		end
	end

	always_ff @(posedge tgt_m_aclk or negedge tgt_m_aresetn) begin
		if (!tgt_m_aresetn) begin
			state     <= ST_IDLE;
			s_term    <= 1'b0;
			s_ready   <= 1'b0;
			s_abort   <= 1'b0;
			abort_evt <= 1'b0;
		end else begin
			abort_evt <= 1'b0;
			case (state)
				ST_IDLE: begin
					if (base_hit != 2'b00)
						state <= ST_DECODE;
				end
				ST_DECODE: begin
					if (!req_mem) begin   // register access done in one cycle
						s_term  <= 1'b1;
						s_ready <= 1'b1;
						state   <= ST_HOLD;
					end else if (!win_cfg.enable) begin
						s_term    <= 1'b1;
						s_abort   <= 1'b1;
						abort_evt <= 1'b1;
						state     <= ST_HOLD;
					end else begin
						state <= ST_MEM;
					end
				end
				ST_MEM: begin
					if (wr_done || rd_done) begin
						s_term    <= 1'b1;
						s_ready   <= seq_ok;
						s_abort   <= !seq_ok;
						abort_evt <= !seq_ok;
						state     <= ST_HOLD;
					end
				end
				ST_HOLD: begin
					if (s_data_vld || !s_data) begin
						s_term  <= 1'b0;
						s_ready <= 1'b0;
						s_abort <= 1'b0;
						state   <= ST_IDLE;
					end
				end
				default: state <= ST_IDLE;
			endcase
		end
	end

	always_ff @(posedge tgt_m_aclk) begin
		if (reg_rd)
			adio_in <= reg_rsp.rdata;
		else if (state == ST_MEM && rd_done)
			adio_in <= r_q.data;
	end

	// ########################################
	// write sequencer

	always_ff @(posedge tgt_m_aclk or negedge tgt_m_aresetn) begin
		if (!tgt_m_aresetn) begin
			ws      <= WS_IDLE;
			awvalid <= 1'b0;
			wvalid  <= 1'b0;
			bready  <= 1'b0;
		end else begin
			case (ws)
				WS_IDLE: begin
					if (wr_start) begin
						awvalid <= 1'b1;
						wvalid  <= 1'b1;
						ws      <= WS_REQ;
					end
				end
				WS_REQ, WS_ACK: begin
					if (awready)
						awvalid <= 1'b0;
					if (wready)
						wvalid <= 1'b0;
					if ((!awvalid || awready) && (!wvalid || wready)) begin
						bready <= 1'b1;
						ws     <= WS_WAIT;
					end else begin
						ws <= WS_ACK;
					end
				end
				WS_WAIT: begin
					if (bvalid) begin
						bready <= 1'b0;
						ws     <= WS_DONE;
					end
				end
				WS_DONE: ws <= WS_IDLE;  // seen by the PCI side this cycle
				default: ws <= WS_IDLE;
			endcase
		end
	end

	always_ff @(posedge tgt_m_aclk) begin
		if (wr_start) begin
			aw.addr <= axi_addr;
			w.data  <= req.data;
			w.strb  <= req.be;
		end
		if (bvalid && bready)
			b_resp_q <= b.resp;
	end

	// ########################################
	// read sequencer

	always_ff @(posedge tgt_m_aclk or negedge tgt_m_aresetn) begin
		if (!tgt_m_aresetn) begin
			rs      <= RS_IDLE;
			arvalid <= 1'b0;
			rready  <= 1'b0;
		end else begin
			case (rs)
				RS_IDLE: begin
					if (rd_start) begin
						arvalid <= 1'b1;
						rs      <= RS_ASTB;
					end
				end
				RS_ASTB, RS_AWAIT: begin
					if (arready) begin
						arvalid <= 1'b0;
						rready  <= 1'b1;
						rs      <= RS_DWAIT;
					end else begin
						rs <= RS_AWAIT;
					end
				end
				RS_DWAIT: begin
					if (rvalid) begin
						rready <= 1'b0;
						rs     <= RS_DONE;
					end
				end
				RS_DONE: rs <= RS_IDLE;
				default: rs <= RS_IDLE;
			endcase
		end
	end

	always_ff @(posedge tgt_m_aclk) begin
		if (rd_start)
			ar.addr <= axi_addr;
		if (rvalid && rready)
			r_q <= r;
	end

endmodule

/* hw/pci_win_regs.sv */
`timescale 1ns/1ps

module pci_win_regs import pci_pkg::*; #(
	parameter int WIN_BITS = 24
) (
	input  logic     tgt_m_aclk,
	input  logic     tgt_m_aresetn,
	input  logic     reg_wr,
	input  logic     reg_rd,
	input  pci_req_t reg_req,
	input  logic     abort_evt,
	output reg_rsp_t reg_rsp,
	output win_cfg_t win_cfg
);

	// low WIN_BITS come from the PCI address, never from the base
	localparam logic [31:0] BASE_MASK = ~((32'd1 << WIN_BITS) - 32'd1);

	logic [31:0] base_q;
	logic [31:0] base_merged;
	logic        enable_q;
	logic [15:0] abort_cnt;
	logic [1:0]  idx;

	assign idx = reg_req.addr.regs.idx;

	assign win_cfg.base   = base_q;
	assign win_cfg.enable = enable_q;

	always_comb begin
		base_merged = base_q;
		for (int i = 0; i < 4; i++) begin
			if (reg_req.be[i])
				base_merged[8*i +: 8] = reg_req.data[8*i +: 8];
		end
	end

	always_ff @(posedge tgt_m_aclk or negedge tgt_m_aresetn) begin
		if (!tgt_m_aresetn) begin
			base_q    <= '0;
			enable_q  <= 1'b1;
			abort_cnt <= '0;
		end else begin
			if (reg_wr && idx == REG_WIN_BASE)
				base_q <= base_merged & BASE_MASK;
			if (reg_wr && idx == REG_CTRL && reg_req.be[0])
				enable_q <= reg_req.data[0];
			if (abort_evt && abort_cnt != '1)  // saturates
				abort_cnt <= abort_cnt + 1'b1;
		end
	end

	always_comb begin
		reg_rsp.rdata = '0;
		if (reg_rd) begin
			case (idx)
				REG_WIN_BASE:  reg_rsp.rdata = base_q;
				REG_CTRL:      reg_rsp.rdata = {31'd0, enable_q};
				REG_ABORT_CNT: reg_rsp.rdata = {16'd0, abort_cnt};
				default:       reg_rsp.rdata = '0;
			endcase
		end
	end

endmodule

/* run_sim.sh */
#!/usr/bin/env bash
# build and run the PCI bridge testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal \
	-f src.f \
	--top-module tb_pci_bridge \
	-Mdir obj_dir \
	-o sim_tb_pci_bridge
build_status=$?
if [ $build_status -ne 0 ]; then
	echo "verilator build failed with status $build_status"
	exit $build_status
fi

./obj_dir/sim_tb_pci_bridge
sim_status=$?
if [ $sim_status -ne 0 ]; then
	echo "simulation failed with status $sim_status"
	exit $sim_status
fi

exit 0

/* src.f */
hw/pci_pkg.sv
hw/axil_pkg.sv
hw/pci_win_regs.sv
hw/axil_sram.sv
hw/pci_target.sv
hw/pci_bridge_top.sv
test/tb_pci_bridge.sv

/* test/tb_pci_bridge.sv */
`timescale 1ns/1ps

module tb_pci_bridge import pci_pkg::*; ();

	localparam int N_TXN          = 26;
	localparam int TIMEOUT_CYCLES = N_TXN * 40;
	localparam logic BAR_MEM = 1'b0;
	localparam logic BAR_REG = 1'b1;

	typedef struct {
		logic        bar;        // 0 memory window, 1 registers
		pci_req_t    req;
		logic [31:0] exp_data;
		logic        exp_abort;
		logic        fixed_lat;  // termination due exactly 2 cycles after base_hit
	} txn_t;

	logic        tgt_m_aclk;
	logic        tgt_m_aresetn;
	logic [31:0] addr;
	logic [31:0] adio_out;
	logic [1:0]  base_hit;
	logic        s_wrdn;
	logic        s_data;
	logic        s_data_vld;
	logic [3:0]  s_cbe;
	logic [31:0] adio_in;
	logic        s_ready;
	logic        s_term;
	logic        s_abort;

	txn_t        txns [N_TXN];
	int          n_built = 0;
	int          cycle_cnt = 0;
	logic [31:0] rnd [5];

	pci_bridge_top pci_bridge_top_inst (
		.tgt_m_aclk    (tgt_m_aclk),
		.tgt_m_aresetn (tgt_m_aresetn),
		.addr          (addr),
		.adio_out      (adio_out),
		.base_hit      (base_hit),
		.s_wrdn        (s_wrdn),
		.s_data        (s_data),
		.s_data_vld    (s_data_vld),
		.s_cbe         (s_cbe),
		.adio_in       (adio_in),
		.s_ready       (s_ready),
		.s_term        (s_term),
		.s_abort       (s_abort)
	);

	initial begin
		tgt_m_aclk = 1'b0;
		forever #2 tgt_m_aclk = ~tgt_m_aclk;
	end

	always @(posedge tgt_m_aclk) begin
		cycle_cnt = cycle_cnt + 1;
		if (cycle_cnt >= TIMEOUT_CYCLES) begin
			$display("timeout waiting for target termination");
			$display("Regression failed");
			$fatal(1, "run stopped after %0d cycles", cycle_cnt);
		end
	end

	// ########################################
	// compare tasks

	task automatic check_data(input logic [31:0] got, input logic [31:0] exp,
			input string what);
		if (got !== exp) begin
			$display("** Error at %0d ns: %s adio_in got %h expected %h", $time, what, got, exp);
			$display("Regression failed");
			$fatal(1, "read data mismatch");
		end
	endtask

	task automatic check_status(input logic got_term, input logic got_ready,
			input logic got_abort, input logic exp_term, input logic exp_abort,
			input string what);
		logic exp_ready;
		logic exp_ab;
		exp_ready = exp_term && !exp_abort;
		exp_ab    = exp_term && exp_abort;
		if (got_term !== exp_term || got_ready !== exp_ready || got_abort !== exp_ab) begin
			$display("** Error at %0d ns: %s term/ready/abort got %b%b%b expected %b%b%b",
				$time, what, got_term, got_ready, got_abort, exp_term, exp_ready, exp_ab);
			$display("Regression failed");
			$fatal(1, "termination status mismatch");
		end
	endtask

	task automatic check_cycles(input int got, input int exp, input string what);
		if (got != exp) begin
			$display("** Error at %0d ns: %s termination after %0d cycles expected %0d",
				$time, what, got, exp);
			$display("Regression failed");
			$fatal(1, "termination latency mismatch");
		end
	endtask

	// ########################################
	// transaction table

	task automatic add_txn(input logic bar, input logic wrdn, input logic [31:0] a,
			input logic [31:0] d, input logic [3:0] be, input logic [31:0] exp_d,
			input logic exp_ab, input logic fixed);
		txn_t t;
		t.bar       = bar;
		t.req.addr  = a;
		t.req.data  = d;
		t.req.be    = be;
		t.req.wrdn  = wrdn;
		t.exp_data  = exp_d;
		t.exp_abort = exp_ab;
		t.fixed_lat = fixed;
		txns[n_built] = t;
		n_built++;
	endtask

	task automatic build_table();
		int aborts;
		for (int k = 0; k < 5; k++)
			rnd[k] = $urandom();
		// plain write then read back
		add_txn(BAR_MEM, 1'b1, 32'h0000_0010, rnd[0], 4'hF, 32'h0, 1'b0, 1'b0);
		add_txn(BAR_MEM, 1'b0, 32'h0000_0010, 32'h0, 4'hF, rnd[0], 1'b0, 1'b0);
		// partial byte enables on lanes 0 and 2
		add_txn(BAR_MEM, 1'b1, 32'h0000_0020, rnd[1], 4'hF, 32'h0, 1'b0, 1'b0);
		add_txn(BAR_MEM, 1'b1, 32'h0000_0020, rnd[2], 4'b0101, 32'h0, 1'b0, 1'b0);
		add_txn(BAR_MEM, 1'b0, 32'h0000_0020, 32'h0, 4'hF,
			{rnd[1][31:24], rnd[2][23:16], rnd[1][15:8], rnd[2][7:0]}, 1'b0, 1'b0);
		add_txn(BAR_MEM, 1'b1, 32'h0000_03FC, rnd[3], 4'hF, 32'h0, 1'b0, 1'b0);  // last word
		add_txn(BAR_MEM, 1'b0, 32'h0000_03FC, 32'h0, 4'hF, rnd[3], 1'b0, 1'b0);
		// beyond the memory depth
		add_txn(BAR_MEM, 1'b1, 32'h0000_0400, 32'h1234_5678, 4'hF, 32'h0, 1'b1, 1'b0);
		add_txn(BAR_MEM, 1'b0, 32'h0000_1000, 32'h0, 4'hF, 32'h0, 1'b1, 1'b0);
		// move the window base away from the memory
		add_txn(BAR_REG, 1'b1, 32'h0000_0000, 32'h0300_0000, 4'hF, 32'h0, 1'b0, 1'b1);
		add_txn(BAR_REG, 1'b0, 32'h0000_0000, 32'h0, 4'hF, 32'h0300_0000, 1'b0, 1'b1);
		add_txn(BAR_MEM, 1'b0, 32'h0000_0010, 32'h0, 4'hF, 32'h0, 1'b1, 1'b0);
		// low bits of the base are not held
		add_txn(BAR_REG, 1'b1, 32'h0000_0000, 32'h00FF_FFFF, 4'hF, 32'h0, 1'b0, 1'b1);
		add_txn(BAR_REG, 1'b0, 32'h0000_0000, 32'h0, 4'hF, 32'h0, 1'b0, 1'b1);
		add_txn(BAR_MEM, 1'b0, 32'h0700_0010, 32'h0, 4'hF, rnd[0], 1'b0, 1'b0);  // other page
		add_txn(BAR_MEM, 1'b1, 32'h5A00_0030, rnd[4], 4'hF, 32'h0, 1'b0, 1'b0);
		add_txn(BAR_MEM, 1'b0, 32'h0000_0030, 32'h0, 4'hF, rnd[4], 1'b0, 1'b0);
		// window disabled
		add_txn(BAR_REG, 1'b1, 32'h0000_0004, 32'h0000_0000, 4'b0001, 32'h0, 1'b0, 1'b1);
		add_txn(BAR_REG, 1'b0, 32'h0000_0004, 32'h0, 4'hF, 32'h0, 1'b0, 1'b1);
		add_txn(BAR_MEM, 1'b1, 32'h0000_0010, 32'hDEAD_BEEF, 4'hF, 32'h0, 1'b1, 1'b1);
		add_txn(BAR_MEM, 1'b0, 32'h0000_0010, 32'h0, 4'hF, 32'h0, 1'b1, 1'b1);
		add_txn(BAR_REG, 1'b1, 32'h0000_0004, 32'h0000_0001, 4'b0001, 32'h0, 1'b0, 1'b1);
		add_txn(BAR_REG, 1'b0, 32'h0000_0004, 32'h0, 4'hF, 32'h1, 1'b0, 1'b1);
		add_txn(BAR_MEM, 1'b0, 32'h0000_0010, 32'h0, 4'hF, rnd[0], 1'b0, 1'b0);
		add_txn(BAR_REG, 1'b0, 32'h0000_000C, 32'h0, 4'hF, 32'h0, 1'b0, 1'b1);  // unused index
		add_txn(BAR_REG, 1'b0, 32'h0000_0008, 32'h0, 4'hF, 32'h0, 1'b0, 1'b1);
		// abort counter read closes the table
		aborts = 0;
		for (int k = 0; k < N_TXN - 1; k++) begin
			if (txns[k].exp_abort)
				aborts++;
		end
		txns[N_TXN-1].exp_data = aborts;
	endtask

	// ########################################
	// driver

	task automatic run_txn(input int i);
		txn_t  t;
		int    cycles;
		string what;
		t    = txns[i];
		what = $sformatf("txn %0d", i);
		addr     = t.req.addr;
		adio_out = t.req.data;
		s_cbe    = ~t.req.be;
		s_wrdn   = t.req.wrdn;
		base_hit = t.bar ? 2'b10 : 2'b01;
		s_data   = 1'b1;
		@(negedge tgt_m_aclk);
		base_hit = 2'b00;
		cycles   = 1;
		while (!s_term) begin
			@(negedge tgt_m_aclk);
			cycles++;
		end
		check_status(s_term, s_ready, s_abort, 1'b1, t.exp_abort, what);
		if (t.fixed_lat)
			check_cycles(cycles, 2, what);
		if (!t.req.wrdn && !t.exp_abort)
			check_data(adio_in, t.exp_data, what);
		s_data_vld = 1'b1;
		@(negedge tgt_m_aclk);
		s_data_vld = 1'b0;
		s_data     = 1'b0;
		check_status(s_term, s_ready, s_abort, 1'b0, 1'b0, {what, " release"});
	endtask

	initial begin
		tgt_m_aresetn = 1'b0;
		addr          = '0;
		adio_out      = '0;
		base_hit      = 2'b00;
		s_wrdn        = 1'b0;
		s_data        = 1'b0;
		s_data_vld    = 1'b0;
		s_cbe         = 4'hF;
		void'($urandom(92));
		build_table();
		repeat (4) @(negedge tgt_m_aclk);
		tgt_m_aresetn = 1'b1;
		@(negedge tgt_m_aclk);
		check_status(s_term, s_ready, s_abort, 1'b0, 1'b0, "after reset");
		for (int i = 0; i < N_TXN; i++)
			run_txn(i);
		$display("Regression passed");
		$finish;
	end

endmodule
